// ==== hw/tt_geom_pkg.sv ====
package tt_geom_pkg;

    // A character cell is six dots wide and ten scan lines high.
    localparam int LINES_PER_ROW = 10;
    localparam int DOTS_PER_CHAR = 6;

    // The flash phase is taken from the top two bits of this counter.
    localparam int FLASH_BITS = 20;

    // Scan line inside a character row, 0 to LINES_PER_ROW - 1.
    typedef logic [3:0] scan_line_t;

    // One row of a glyph. The leftmost dot on screen is the MSB.
    typedef logic [DOTS_PER_CHAR-1:0] dot_row_t;

    // Free-running flash counter, advanced once per character.
    typedef logic [FLASH_BITS-1:0] flash_cnt_t;

endpackage

// ==== hw/tt_code_pkg.sv ====
package tt_code_pkg;

    // Teletext character code as it arrives on the data bus.
    typedef logic [6:0] char_code_t;

    // Bit 0 is red, bit 1 green, bit 2 blue.
    typedef logic [2:0] colour_t;

    localparam colour_t COLOUR_BLACK = 3'b000;
    localparam colour_t COLOUR_WHITE = 3'b111;

    // Serial control codes. Colour codes are handled as ranges in the decoder.
    localparam char_code_t CODE_FLASH     = 7'h08;
    localparam char_code_t CODE_STEADY    = 7'h09;
    localparam char_code_t CODE_NORMAL_HT = 7'h0C;
    localparam char_code_t CODE_DOUBLE    = 7'h0D;
    localparam char_code_t CODE_CONTIG    = 7'h19;
    localparam char_code_t CODE_SEPAR     = 7'h1A;
    localparam char_code_t CODE_BLACK_BG  = 7'h1C;
    localparam char_code_t CODE_NEW_BG    = 7'h1D;

    // Double height spans two display rows: the top half, then the bottom half.
    typedef enum logic [1:0] {
        DBL_NONE   = 2'd0,
        DBL_TOP    = 2'd1,
        DBL_BOTTOM = 2'd2
    } dbl_state_t;

endpackage

// ==== hw/char_rom.sv ====
`timescale 1ns/1ps

module char_rom
    import tt_geom_pkg::*;
    import tt_code_pkg::*;
(
    input  char_code_t code,
    input  scan_line_t line,
    output dot_row_t   pattern
);

    // Glyphs are 5 by 7 and sit on scan lines 1 to 7, leaving dot 0 as the gap
    // between characters. Lines 0, 8 and 9 stay blank.
    localparam int GLYPH_ROWS = 7;
    localparam int GLYPH_COLS = 5;

    logic [GLYPH_ROWS*GLYPH_COLS-1:0] glyph;

    // The first row of a glyph is in the top five bits.
    always_comb begin
        case (code)
            7'h20: glyph = '0;
            7'h30: glyph = 35'b01110_10001_10011_10101_11001_10001_01110;
            7'h31: glyph = 35'b00100_01100_00100_00100_00100_00100_01110;
            7'h32: glyph = 35'b01110_10001_00001_00110_01000_10000_11111;
            7'h33: glyph = 35'b11111_00010_00100_00010_00001_10001_01110;
            7'h34: glyph = 35'b00010_00110_01010_10010_11111_00010_00010;
            7'h35: glyph = 35'b11111_10000_11110_00001_00001_10001_01110;
            7'h36: glyph = 35'b00110_01000_10000_11110_10001_10001_01110;
            7'h37: glyph = 35'b11111_00001_00010_00100_01000_01000_01000;
            7'h38: glyph = 35'b01110_10001_10001_01110_10001_10001_01110;
            7'h39: glyph = 35'b01110_10001_10001_01111_00001_00010_01100;
            7'h41: glyph = 35'b00100_01010_10001_10001_11111_10001_10001;
            7'h42: glyph = 35'b11110_10001_10001_11110_10001_10001_11110;
            7'h43: glyph = 35'b01110_10001_10000_10000_10000_10001_01110;
            7'h44: glyph = 35'b11110_10001_10001_10001_10001_10001_11110;
            7'h45: glyph = 35'b11111_10000_10000_11110_10000_10000_11111;
            7'h46: glyph = 35'b11111_10000_10000_11110_10000_10000_10000;
            7'h47: glyph = 35'b01110_10001_10000_10000_10011_10001_01111;
            7'h48: glyph = 35'b10001_10001_10001_11111_10001_10001_10001;
            // Control codes and glyphs outside the subset show as blank cells.
            default: glyph = '0;
        endcase
    end

    always_comb begin
        if (line >= 4'd1 && line <= scan_line_t'(GLYPH_ROWS)) begin
            pattern = {glyph[(GLYPH_ROWS - int'(line)) * GLYPH_COLS +: GLYPH_COLS], 1'b0};
        end else begin
            pattern = '0;
        end
    end

endmodule

// ==== hw/row_tracker.sv ====
`timescale 1ns/1ps

module row_tracker
    import tt_geom_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       char_strobe,
    input  logic       hsync,
    input  logic       vsync,
    output scan_line_t line,
    output logic       new_row
);

    localparam scan_line_t LAST_LINE = scan_line_t'(LINES_PER_ROW - 1);

    logic hsync_prev;
    logic hsync_fall;

    // hsync is only looked at on character strobes, so a falling edge is seen
    // in the strobe cycle that follows it.
    assign hsync_fall = char_strobe && hsync_prev && !hsync;

    // A new character row starts when the last scan line ends.
    assign new_row = hsync_fall && (line == LAST_LINE);

    always_ff @(posedge CLK) begin
        if (rst) begin
            hsync_prev <= 1'b0;
        end else if (char_strobe) begin
            hsync_prev <= hsync;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            line <= '0;
        end else if (char_strobe) begin
            if (vsync) begin
                line <= '0;
            end else if (hsync_fall) begin
                line <= (line == LAST_LINE) ? scan_line_t'(0) : line + 1'b1;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (rst) line <= LAST_LINE)
        else $error("row_tracker: scan line %0d past end of row", line);

endmodule

// ==== hw/attr_decoder.sv ====
`timescale 1ns/1ps

module attr_decoder
    import tt_geom_pkg::*;
    import tt_code_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       char_strobe,
    input  logic       lose,
    input  logic       new_row,
    input  char_code_t data,
    output char_code_t code,
    output logic       is_mosaic,
    output logic       contiguous,
    output logic       dbl_height,
    output logic       dbl_bottom,
    output colour_t    fg_colour,
    output colour_t    bg_colour,
    output logic       flash_blank
);

    colour_t    alpha_colour;
    colour_t    mosaic_colour;
    colour_t    bg_reg;
    logic       flash;
    logic       graphics;
    logic       is_ctrl;
    dbl_state_t dbl_state;
    flash_cnt_t flash_cnt;

    // Codes 0x00 to 0x1F are control codes, acted on only while the display is enabled.
    assign is_ctrl = lose && (code[6:5] == 2'b00);

    always_ff @(posedge CLK) begin
        if (rst) begin
            code <= '0;
        end else if (char_strobe) begin
            code <= data;
        end
    end

    // Colour and flash are set-after. The registers change as the control
    // character itself goes down the pipeline.
    always_ff @(posedge CLK) begin
        if (rst || (char_strobe && new_row)) begin
            alpha_colour <= COLOUR_WHITE;
            flash        <= 1'b0;
            dbl_height   <= 1'b0;
            contiguous   <= 1'b1;
            graphics     <= 1'b0;
            bg_reg       <= COLOUR_BLACK;
            if (rst) begin
                mosaic_colour <= COLOUR_WHITE;
            end
        end else if (char_strobe && is_ctrl) begin
            case (code) inside
                [7'h01:7'h07]: begin
                    alpha_colour <= colour_t'(code[2:0]);
                    graphics     <= 1'b0;
                end
                [7'h11:7'h17]: begin
                    mosaic_colour <= colour_t'(code[2:0]);
                    graphics      <= 1'b1;
                end
                CODE_FLASH:     flash <= 1'b1;
                CODE_STEADY:    flash <= 1'b0;
                CODE_DOUBLE:    dbl_height <= 1'b1;
                CODE_NORMAL_HT: dbl_height <= 1'b0;
                CODE_CONTIG: begin
                    contiguous <= 1'b1;
                    graphics   <= 1'b1;
                end
                CODE_SEPAR: begin
                    contiguous <= 1'b0;
                    graphics   <= 1'b1;
                end
                CODE_BLACK_BG: bg_reg <= COLOUR_BLACK;
                CODE_NEW_BG:   bg_reg <= alpha_colour;
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            dbl_state <= DBL_NONE;
            flash_cnt <= '0;
        end else if (char_strobe) begin
            flash_cnt <= flash_cnt + 1'b1;
            unique case (dbl_state)
                DBL_NONE:   if (is_ctrl && code == CODE_DOUBLE && !new_row) dbl_state <= DBL_TOP;
                DBL_TOP:    if (new_row) dbl_state <= DBL_BOTTOM;
                DBL_BOTTOM: if (new_row) dbl_state <= DBL_NONE;
                default:    dbl_state <= DBL_NONE;
            endcase
        end
    end

    assign is_mosaic   = graphics && code[5];
    assign fg_colour   = is_mosaic ? mosaic_colour : alpha_colour;
    assign dbl_bottom  = (dbl_state == DBL_BOTTOM);
    assign flash_blank = flash && (flash_cnt[FLASH_BITS-1 -: 2] == 2'b00);

    // Background is set-at, so the control cell already shows the new colour.
    assign bg_colour = (is_ctrl && code == CODE_BLACK_BG) ? COLOUR_BLACK :
                       (is_ctrl && code == CODE_NEW_BG)   ? alpha_colour : bg_reg;

    // The row defaults are only restored on a strobe, so a row boundary must come with one.
    assert property (@(posedge CLK) disable iff (rst) new_row |-> char_strobe)
        else $error("attr_decoder: new row flagged outside a character strobe");

endmodule

// ==== hw/dot_pipeline.sv ====
`timescale 1ns/1ps

module dot_pipeline
    import tt_geom_pkg::*;
    import tt_code_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       char_strobe,
    input  logic       dot_strobe,
    input  logic       lose,
    input  scan_line_t line,
    input  char_code_t code,
    input  logic       is_mosaic,
    input  logic       contiguous,
    input  logic       dbl_height,
    input  logic       dbl_bottom,
    input  colour_t    fg_colour,
    input  colour_t    bg_colour,
    input  logic       flash_blank,
    output colour_t    rgb
);

    localparam scan_line_t LAST_LINE = scan_line_t'(LINES_PER_ROW - 1);
    localparam scan_line_t HALF_ROW  = scan_line_t'(LINES_PER_ROW / 2);

    scan_line_t half_line;
    scan_line_t bottom_line;
    scan_line_t eff_line;
    logic [1:0] segment;
    logic       band_end;
    dot_row_t   mosaic_dots;
    dot_row_t   glyph_dots;

    dot_row_t   dots_s1;
    colour_t    fg_s1;
    colour_t    bg_s1;
    logic       flash_s1;
    logic       lose_s1;

    dot_row_t   shifter;
    colour_t    fg_s2;
    colour_t    bg_s2;
    logic       flash_s2;
    logic       lose_s2;

    // Double height shows each glyph line twice, from the top half in the first
    // row and from the bottom half in the second.
    assign half_line   = line >> 1;
    assign bottom_line = half_line + HALF_ROW;

    always_comb begin
        if (!dbl_height) begin
            eff_line = line;
        end else if (dbl_bottom) begin
            eff_line = (bottom_line > LAST_LINE) ? LAST_LINE : bottom_line;
        end else begin
            eff_line = half_line;
        end
    end

    // Mosaic cells are three bands of two blocks each. Bit 5 of the code is not a block.
    always_comb begin
        band_end = 1'b0;
        if (eff_line <= 4'd2) begin
            segment  = {code[0], code[1]};
            band_end = (eff_line == 4'd2);
        end else if (eff_line <= 4'd6) begin
            segment  = {code[2], code[3]};
            band_end = (eff_line == 4'd6);
        end else begin
            segment  = {code[4], code[6]};
            band_end = (eff_line == LAST_LINE);
        end
        if (band_end && !contiguous) begin
            segment = 2'b00;
        end
    end

    // Separated blocks lose their left dot.
    assign mosaic_dots = {contiguous & segment[1], segment[1], segment[1],
                          contiguous & segment[0], segment[0], segment[0]};

    char_rom char_rom_i (
        .code    (code),
        .line    (eff_line),
        .pattern (glyph_dots)
    );

    always_ff @(posedge CLK) begin
        if (rst) begin
            dots_s1  <= '0;
            fg_s1    <= COLOUR_BLACK;
            bg_s1    <= COLOUR_BLACK;
            flash_s1 <= 1'b0;
            lose_s1  <= 1'b0;
        end else if (char_strobe) begin
            dots_s1  <= is_mosaic ? mosaic_dots : glyph_dots;
            fg_s1    <= fg_colour;
            bg_s1    <= bg_colour;
            flash_s1 <= flash_blank;
            lose_s1  <= lose;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            shifter  <= '0;
            fg_s2    <= COLOUR_BLACK;
            bg_s2    <= COLOUR_BLACK;
            flash_s2 <= 1'b0;
            lose_s2  <= 1'b0;
        end else if (char_strobe) begin
            shifter  <= dots_s1;
            fg_s2    <= fg_s1;
            bg_s2    <= bg_s1;
            flash_s2 <= flash_s1;
            lose_s2  <= lose_s1;
        end else if (dot_strobe) begin
            shifter <= shifter << 1;
        end
    end

    assign rgb = !lose_s2 ? COLOUR_BLACK :
                 (shifter[DOTS_PER_CHAR-1] && !flash_s2) ? fg_s2 : bg_s2;

    assert property (@(posedge CLK) disable iff (rst) !(char_strobe && dot_strobe))
        else $error("dot_pipeline: character and dot strobes high together");

endmodule

// ==== hw/teletext_gen.sv ====
`timescale 1ns/1ps

module teletext_gen
    import tt_geom_pkg::*;
    import tt_code_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic       char_strobe,
    input  logic       dot_strobe,
    input  logic       vsync,
    input  logic       hsync,
    input  logic       lose,
    input  char_code_t data,
    output colour_t    rgb
);

    scan_line_t line;
    logic       new_row;
    char_code_t code;
    logic       is_mosaic;
    logic       contiguous;
    logic       dbl_height;
    logic       dbl_bottom;
    colour_t    fg_colour;
    colour_t    bg_colour;
    logic       flash_blank;

    row_tracker row_tracker_i (
        .CLK         (CLK),
        .rst         (rst),
        .char_strobe (char_strobe),
        .hsync       (hsync),
        .vsync       (vsync),
        .line        (line),
        .new_row     (new_row)
    );

    attr_decoder attr_decoder_i (
        .CLK         (CLK),
        .rst         (rst),
        .char_strobe (char_strobe),
        .lose        (lose),
        .new_row     (new_row),
        .data        (data),
        .code        (code),
        .is_mosaic   (is_mosaic),
        .contiguous  (contiguous),
        .dbl_height  (dbl_height),
        .dbl_bottom  (dbl_bottom),
        .fg_colour   (fg_colour),
        .bg_colour   (bg_colour),
        .flash_blank (flash_blank)
    );

    dot_pipeline dot_pipeline_i (
        .CLK         (CLK),
        .rst         (rst),
        .char_strobe (char_strobe),
        .dot_strobe  (dot_strobe),
        .lose        (lose),
        .line        (line),
        .code        (code),
        .is_mosaic   (is_mosaic),
        .contiguous  (contiguous),
        .dbl_height  (dbl_height),
        .dbl_bottom  (dbl_bottom),
        .fg_colour   (fg_colour),
        .bg_colour   (bg_colour),
        .flash_blank (flash_blank),
        .rgb         (rgb)
    );

endmodule

// ==== dv/tb_teletext_gen.sv ====
`timescale 1ns/1ps

module tb_teletext_gen
    import tt_geom_pkg::*;
    import tt_code_pkg::*;
();

    localparam int MAX_ENTRIES = 512;

    logic       CLK;
    logic       rst;
    logic       char_strobe;
    logic       dot_strobe;
    logic       vsync;
    logic       hsync;
    logic       lose;
    char_code_t data;
    colour_t    rgb;

    // One entry per character period. exp_rgb holds six RGB triples, dot 0 in the top bits.
    char_code_t  stim_code [MAX_ENTRIES];
    logic        stim_lose [MAX_ENTRIES];
    logic        stim_hs [MAX_ENTRIES];
    logic        stim_vs [MAX_ENTRIES];
    logic [17:0] exp_rgb [MAX_ENTRIES];
    int          n_entries = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    // Reference model state, stepped once per character strobe.
    scan_line_t  m_line = '0;
    logic        m_hs_prev = 1'b0;
    char_code_t  m_code = '0;
    colour_t     m_alpha = 3'b111;
    colour_t     m_mos = 3'b111;
    colour_t     m_bg = 3'b000;
    logic        m_flash = 1'b0;
    logic        m_gfx = 1'b0;
    logic        m_contig = 1'b1;
    logic        m_dblh = 1'b0;
    dbl_state_t  m_dstate = DBL_NONE;
    flash_cnt_t  m_fcnt = '0;

    teletext_gen teletext_gen_i (
        .CLK         (CLK),
        .rst         (rst),
        .char_strobe (char_strobe),
        .dot_strobe  (dot_strobe),
        .vsync       (vsync),
        .hsync       (hsync),
        .lose        (lose),
        .data        (data),
        .rgb         (rgb)
    );

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("ERROR: stimulus table not finished after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input colour_t got, input colour_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Glyphs are 5 by 7 on scan lines 1 to 7, with the rightmost dot left blank.
    function automatic dot_row_t glyph_row(input char_code_t c, input scan_line_t ln);
        logic [34:0] g;
        case (c)
            7'h41:   g = {5'b00100, 5'b01010, 5'b10001, 5'b10001, 5'b11111, 5'b10001, 5'b10001};
            7'h48:   g = {5'b10001, 5'b10001, 5'b10001, 5'b11111, 5'b10001, 5'b10001, 5'b10001};
            7'h30:   g = {5'b01110, 5'b10001, 5'b10011, 5'b10101, 5'b11001, 5'b10001, 5'b01110};
            default: g = '0;
        endcase
        return (ln >= 4'd1 && ln <= 4'd7) ? {g[(7 - int'(ln)) * 5 +: 5], 1'b0} : 6'b0;
    endfunction

    // Three bands of two blocks; separated mode drops each band's last line and left dots.
    function automatic dot_row_t mosaic_row(input char_code_t c, input scan_line_t ln,
                                            input logic contig);
        logic [1:0] blk;
        blk = (ln < 4'd3) ? {c[0], c[1]} : (ln < 4'd7) ? {c[2], c[3]} : {c[4], c[6]};
        if (!contig && (ln == 4'd2 || ln == 4'd6 || ln == 4'd9)) begin
            blk = 2'b00;
        end
        return {{3{blk[1]}} & {contig, 2'b11}, {3{blk[0]}} & {contig, 2'b11}};
    endfunction

    function automatic char_code_t random_mosaic();
        logic [31:0] r;
        r = $urandom;
        return {r[6], 1'b1, r[4:0]};
    endfunction

    task automatic add_entry(input char_code_t c, input logic l, input logic hs, input logic vs);
        stim_code[n_entries] = c;
        stim_lose[n_entries] = l;
        stim_hs[n_entries] = hs;
        stim_vs[n_entries] = vs;
        n_entries++;
    endtask

    // Five codes on every scan line of a row, hsync raised on the fifth.
    task automatic fill_row(input logic [34:0] codes, input logic l);
        for (int ln = 0; ln < LINES_PER_ROW; ln++) begin
            for (int k = 0; k < 5; k++) begin
                add_entry(codes[34 - 7 * k -: 7], l, k == 4, 1'b0);
            end
        end
    endtask

    // Strobe s registers the dots and colours of character s-1 from the state left by
    // the earlier strobes, then the state takes in the code registered at s-1.
    task automatic model_step(input int s);
        logic        fall;
        logic        nr;
        logic        ctrl;
        logic        mos_cell;
        logic        fb;
        scan_line_t  el;
        dot_row_t    dots;
        colour_t     fg;
        colour_t     bgc;
        logic [17:0] pix;
        fall = m_hs_prev && !stim_hs[s];
        nr = fall && (m_line == 4'd9);
        ctrl = stim_lose[s] && (m_code < 7'h20);
        el = m_line;
        if (m_dblh) begin
            el = (m_dstate == DBL_BOTTOM) ? (m_line >> 1) + 4'd5 : m_line >> 1;
        end
        mos_cell = m_gfx && m_code[5];
        dots = mos_cell ? mosaic_row(m_code, el, m_contig) : glyph_row(m_code, el);
        fg = mos_cell ? m_mos : m_alpha;
        bgc = (ctrl && m_code == CODE_BLACK_BG) ? 3'b000 :
              (ctrl && m_code == CODE_NEW_BG) ? m_alpha : m_bg;
        fb = m_flash && (m_fcnt[FLASH_BITS-1 -: 2] == 2'b00);
        for (int i = 0; i < DOTS_PER_CHAR; i++) begin
            pix[17 - 3 * i -: 3] = !stim_lose[s] ? 3'b000 : (dots[5 - i] && !fb) ? fg : bgc;
        end
        if (s > 0) begin
            exp_rgb[s - 1] = pix;
        end
        case (m_dstate)
            DBL_NONE: m_dstate = (ctrl && m_code == CODE_DOUBLE && !nr) ? DBL_TOP : DBL_NONE;
            DBL_TOP:  m_dstate = nr ? DBL_BOTTOM : DBL_TOP;
            default:  m_dstate = nr ? DBL_NONE : DBL_BOTTOM;
        endcase
        if (nr) begin
            m_alpha = 3'b111;
            m_flash = 1'b0;
            m_dblh = 1'b0;
            m_contig = 1'b1;
            m_gfx = 1'b0;
            m_bg = 3'b000;
        end else if (ctrl) begin
            case (m_code)
                CODE_FLASH:     m_flash = 1'b1;
                CODE_STEADY:    m_flash = 1'b0;
                CODE_DOUBLE:    m_dblh = 1'b1;
                CODE_NORMAL_HT: m_dblh = 1'b0;
                CODE_BLACK_BG:  m_bg = 3'b000;
                CODE_NEW_BG:    m_bg = m_alpha;
                CODE_CONTIG, CODE_SEPAR: begin
                    m_contig = (m_code == CODE_CONTIG);
                    m_gfx = 1'b1;
                end
                default: begin
                    if (m_code[2:0] != 3'd0 && m_code[4:3] == 2'b00) begin
                        m_alpha = m_code[2:0];
                        m_gfx = 1'b0;
                    end else if (m_code[2:0] != 3'd0 && m_code[4:3] == 2'b10) begin
                        m_mos = m_code[2:0];
                        m_gfx = 1'b1;
                    end
                end
            endcase
        end
        m_fcnt = m_fcnt + 1'b1;
        m_line = stim_vs[s] ? 4'd0 : !fall ? m_line : (m_line == 4'd9) ? 4'd0 : m_line + 4'd1;
        m_hs_prev = stim_hs[s];
        m_code = stim_code[s];
    endtask

    initial begin
        void'($urandom(32'h8061));
        CLK = 1'b0;
        rst = 1'b1;
        char_strobe = 1'b0;
        dot_strobe = 1'b0;
        vsync = 1'b0;
        hsync = 1'b0;
        lose = 1'b0;
        data = '0;

        add_entry(7'h20, 1'b1, 1'b0, 1'b1);
        fill_row({7'h41, 7'h48, 7'h30, 7'h20, 7'h20}, 1'b1);
        fill_row({7'h01, 7'h41, 7'h48, 7'h30, 7'h20}, 1'b1);
        fill_row({7'h41, 7'h04, CODE_NEW_BG, 7'h48, CODE_BLACK_BG}, 1'b1);
        fill_row({7'h12, random_mosaic(), random_mosaic(), random_mosaic(), random_mosaic()},
                 1'b1);
        fill_row({CODE_SEPAR, random_mosaic(), random_mosaic(), random_mosaic(),
                  random_mosaic()}, 1'b1);
        fill_row({CODE_DOUBLE, 7'h41, 7'h48, 7'h30, 7'h20}, 1'b1);
        fill_row({CODE_DOUBLE, 7'h41, 7'h48, 7'h30, 7'h20}, 1'b1);
        fill_row({7'h01, 7'h41, 7'h48, 7'h30, 7'h20}, 1'b0);
        fill_row({CODE_FLASH, 7'h41, CODE_STEADY, 7'h48, 7'h30}, 1'b1);
        // Two spaces flush the last real character through the pipeline.
        add_entry(7'h20, 1'b1, 1'b0, 1'b0);
        add_entry(7'h20, 1'b1, 1'b0, 1'b0);
        for (int s = 0; s < n_entries; s++) begin
            model_step(s);
        end
        cycle_limit = n_entries * DOTS_PER_CHAR + 200;

        repeat (8) @(posedge CLK);
        #2;
        rst = 1'b0;
        check_value("rgb after reset", rgb, 3'b000);
        for (int p = 0; p < n_entries; p++) begin
            char_strobe = 1'b1;
            dot_strobe = 1'b0;
            data = stim_code[p];
            lose = stim_lose[p];
            hsync = stim_hs[p];
            vsync = stim_vs[p];
            for (int i = 0; i < DOTS_PER_CHAR; i++) begin
                @(posedge CLK);
                #2;
                if (p >= 2) begin
                    check_value($sformatf("rgb (char %0d dot %0d)", p - 2, i), rgb,
                                exp_rgb[p - 2][17 - 3 * i -: 3]);
                end
                char_strobe = 1'b0;
                dot_strobe = (i < DOTS_PER_CHAR - 1);
            end
        end

        $display("Pixel checks finished with %0d errors over %0d characters",
                 errors, n_entries - 2);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
hw/tt_geom_pkg.sv
hw/tt_code_pkg.sv
hw/char_rom.sv
hw/row_tracker.sv
hw/attr_decoder.sv
hw/dot_pipeline.sv
hw/teletext_gen.sv
dv/tb_teletext_gen.sv

// ==== Makefile ====
TOP = tb_teletext_gen

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
		echo "$$out" | grep -q "^Simulation completed successfully$$"

clean:
	rm -rf obj_dir
